// ==== verif/afe_trace.txt ====
# W addr wdata exp_err | R addr exp_rdata exp_err | all hex
# S adc_a adc_b exp_dac_a exp_dac_b | M adc_a adc_b | L count | G step count
# reset state, feedback and ramp off
S 0000 3fff 1fff 1fff
S 1000 2abc 1fff 1fff
R 00000000 00000000 0
# feedback only, shift 0 then 2
W 00000000 00000002 0
R 00000000 00000002 0
S 1000 2abc 1000 2abc
S 0123 3210 0123 3210
W 00000000 00000022 0
S 1000 2abc 1c00 22af
S 0000 3fff 1800 27ff
L 8
M 2222 1111
# ramp frozen near positive full scale with feedback
W 00000000 00000000 0
W 00000004 000007c0 0
W 00000000 00000003 0
W 00000004 00000000 0
S 1000 0000 0000 0000
M 3fff 0800
# ramp frozen near negative full scale with feedback
W 00000000 00000000 0
W 00000004 00000840 0
W 00000000 00000003 0
W 00000004 00000000 0
S 3fff 3000 3fff 3fff
M 0000 2000
# free running ramp, feedback off
W 00000000 00000000 0
W 00000004 00000a31 0
R 00000004 00000a31 0
W 00000000 00000001 0
G 00000a31 20
W 00000000 00000000 0
# bus errors and the spare region
W 0000000c 12345678 1
R 0000000c 00000000 1
W 00000008 00000001 1
R 00500000 00000000 0
W 00500000 00000003 0
R 00000000 00000000 0
S 1000 3000 1fff 1fff
R 00000008 efff0fff 0

// ==== verilog.f ====
hdl/afe_pkg.sv
hdl/bus_fsm.sv
hdl/ctrl_regs.sv
hdl/ramp_gen.sv
hdl/code_conv.sv
hdl/mix_sat.sv
hdl/afe_top.sv
verif/afe_checker.sv
verif/tb_afe_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_afe_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the trace, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_afe_top.sv ====
// testbench top for the analog front end core
// clock, reset, trace reader, bus master and adc driver;
// keeps a small model of the register fields for computed samples

`timescale 1ns/100ps
`default_nettype none

module tb_afe_top;

  localparam int unsigned SW = 14;
  localparam int SMAX = (1 << (SW - 1)) - 1;
  localparam int SMIN = -(1 << (SW - 1));
  localparam logic [1:0] K_BUS  = 2'd0;
  localparam logic [1:0] K_SMP  = 2'd1;
  localparam logic [1:0] K_RAMP = 2'd2;

  logic              adc_clk = 1'b0;
  logic              arst_n_i;
  afe_pkg::bus_req_t bus_req;
  afe_pkg::bus_rsp_t bus_rsp;
  logic [SW-1:0]     adc_a;
  logic [SW-1:0]     adc_b;
  logic [SW-1:0]     dac_a;
  logic [SW-1:0]     dac_b;
  logic              exp_push;   // one cycle per record
  logic [1:0]        exp_kind;
  logic [31:0]       exp_a;
  logic [31:0]       exp_b;
  int                chk_errs;
  logic              chk_pend;
  int unsigned       cyc = 0;    // posedge count
  int unsigned       limit = 0;  // timeout, set from trace length
  int                tb_errs = 0;
  logic [15:0]       lfsr_q;
  logic              m_gen;      // register model
  logic              m_fb;
  logic [2:0]        m_shift;
  logic [SW-1:0]     m_step;
  logic [SW-1:0]     m_phase;
  int unsigned       m_last;     // cycle of last model update

  always #5 adc_clk = ~adc_clk;  // 100 MHz

  afe_top #(.SAMPLE_W(SW)) uut (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b)
  );

  afe_checker #(.SAMPLE_W(SW)) chk (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .bus_rsp_i  (bus_rsp),
    .dac_a_i    (dac_a),
    .dac_b_i    (dac_b),
    .exp_push_i (exp_push),
    .exp_kind_i (exp_kind),
    .exp_a_i    (exp_a),
    .exp_b_i    (exp_b),
    .err_cnt_o  (chk_errs),
    .pend_o     (chk_pend)
  );

  //----------------------------------------------------------------------
  // cycle count and timeout
  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit) begin
      $display("timeout after %0d cycles, the trace did not finish", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //----------------------------------------------------------------------
  // reference rules
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [SW-1:0] code_to_value(input logic [SW-1:0] c);
    return {c[SW-1], ~c[SW-2:0]}; // msb kept, rest inverted
  endfunction

  function automatic logic [SW-1:0] phase_at(input int unsigned c);
    logic [31:0] t;
    if (!m_gen) return '0;
    t = 32'(m_phase) + 32'(m_step) * (c - m_last); // wraps in the slice
    return t[SW-1:0];
  endfunction

  function automatic logic [SW-1:0] expect_dac(input logic [SW-1:0] code,
                                               input logic [SW-1:0] phase);
    logic signed [SW-1:0] smp;
    logic signed [SW-1:0] ph_s;
    int                   v;
    logic [31:0]          vb;
    smp  = code_to_value(code);
    ph_s = phase;
    v    = 0;
    if (m_fb) v = int'(smp) >>> m_shift; // arithmetic shift
    if (m_gen) v = v + int'(ph_s);
    if (v > SMAX) v = SMAX;              // clamp
    if (v < SMIN) v = SMIN;
    vb = v;
    return code_to_value(vb[SW-1:0]);
  endfunction

  task automatic draw_sample(output logic [SW-1:0] v);
    v = '0;
    for (int i = 0; i < SW; i++) begin
      lfsr_q = lfsr_next(lfsr_q); // one step per bit
      v      = {v[SW-2:0], lfsr_q[0]};
    end
  endtask

  task automatic update_model(input logic [7:0] off, input logic [31:0] d,
                              input int unsigned c);
    m_phase = phase_at(c); // phase at the strobe edge
    m_last  = c;
    if (off == afe_pkg::REG_CTRL) begin
      m_gen   = d[0];
      m_fb    = d[1];
      m_shift = d[6:4];
      if (!m_gen) m_phase = '0;
    end else if (off == afe_pkg::REG_STEP) begin
      m_step = d[SW-1:0];
    end
  endtask

  //----------------------------------------------------------------------
  // drivers, all called 1 ns after a rising edge
  task automatic bus_op(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                        input logic [31:0] exp_rd, input logic exp_err);
    int unsigned req_cyc;
    int unsigned ack_cyc;
    exp_push      = 1'b1;
    exp_kind      = K_BUS;
    exp_a         = exp_rd;
    exp_b         = {30'd0, ~wr, exp_err}; // bit 1 asks for a data check
    bus_req.addr  = addr;
    bus_req.wdata = data;
    bus_req.wr    = wr;
    bus_req.req   = 1'b1;
    req_cyc       = cyc;
    @(posedge adc_clk);
    #1;
    exp_push = 1'b0;
    while (!bus_rsp.ack) begin
      @(posedge adc_clk);
      #1;
    end
    ack_cyc = cyc;
    if (ack_cyc - req_cyc != 2) begin
      tb_errs++;
      $display("ack came %0d cycles after req instead of 2", ack_cyc - req_cyc);
    end
    bus_req.req = 1'b0; // release phase
    if (wr && !exp_err &&
        addr[afe_pkg::REGION_LSB +: afe_pkg::REGION_W] == afe_pkg::RGN_CTRL)
      update_model(addr[7:0], data, ack_cyc);
    while (bus_rsp.ack) begin
      @(posedge adc_clk);
      #1;
    end
  endtask

  task automatic drive_sample(input logic [SW-1:0] a, input logic [SW-1:0] b,
                              input logic [SW-1:0] ea, input logic [SW-1:0] eb);
    adc_a    = a;
    adc_b    = b;
    exp_push = 1'b1;
    exp_kind = K_SMP;
    exp_a    = 32'(ea);
    exp_b    = 32'(eb);
    @(posedge adc_clk);
    #1;
    exp_push = 1'b0;
  endtask

  task automatic check_ramp(input logic [31:0] step, input int n);
    repeat (2) @(posedge adc_clk); // let the ramp settle
    #1;
    exp_push = 1'b1;
    exp_kind = K_RAMP;
    exp_a    = step;
    exp_b    = n;
    @(posedge adc_clk);
    #1;
    exp_push = 1'b0;
    repeat (n + 1) @(posedge adc_clk);
    #1;
  endtask

  //----------------------------------------------------------------------
  // trace reader
  initial begin
    int            fd;
    int            r;
    int            lines;
    int            n_smp;
    logic [7:0]    op;
    logic [8*160-1:0] line;
    logic [31:0]   x0;
    logic [31:0]   x1;
    logic [31:0]   x2;
    logic [SW-1:0] sa;
    logic [SW-1:0] sb;
    logic [SW-1:0] ea;
    logic [SW-1:0] eb;
    arst_n_i = 1'b0;
    bus_req  = '0;
    adc_a    = '0;
    adc_b    = '0;
    exp_push = 1'b0;
    exp_kind = K_BUS;
    exp_a    = '0;
    exp_b    = '0;
    lfsr_q   = 16'd80;  // seed
    m_gen    = 1'b0;
    m_fb     = 1'b0;
    m_shift  = '0;
    m_step   = '0;
    m_phase  = '0;
    m_last   = 0;
    lines    = 0;
    fd = $fopen("verif/afe_trace.txt", "r");
    if (fd == 0) begin
      tb_errs++;
      $display("cannot open the trace file");
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0) lines++;
      end
      $fclose(fd);
    end
    limit = 20 * lines + 200;
    repeat (4) @(posedge adc_clk); // reset for 4 cycles
    #1;
    arst_n_i = 1'b1;
    if (fd != 0) begin
      fd = $fopen("verif/afe_trace.txt", "r");
      while (!$feof(fd)) begin
        r = $fscanf(fd, " %c", op);
        if (r == 1) begin
          case (op)
            "#": r = $fgets(line, fd); // comment
            "W": begin
              r = $fscanf(fd, "%h %h %h", x0, x1, x2);
              bus_op(1'b1, x0, x1, '0, x2[0]);
            end
            "R": begin
              r = $fscanf(fd, "%h %h %h", x0, x1, x2);
              bus_op(1'b0, x0, '0, x1, x2[0]);
            end
            "S": begin
              r = $fscanf(fd, "%h %h %h %h", sa, sb, ea, eb);
              drive_sample(sa, sb, ea, eb);
            end
            "M": begin
              r = $fscanf(fd, "%h %h", sa, sb);
              drive_sample(sa, sb, expect_dac(sa, phase_at(cyc + 1)),
                           expect_dac(sb, phase_at(cyc + 1)));
            end
            "L": begin
              r = $fscanf(fd, "%d", n_smp);
              repeat (n_smp) begin
                draw_sample(sa);
                draw_sample(sb);
                drive_sample(sa, sb, expect_dac(sa, phase_at(cyc + 1)),
                             expect_dac(sb, phase_at(cyc + 1)));
              end
            end
            "G": begin
              r = $fscanf(fd, "%h %d", x0, n_smp);
              check_ramp(x0, n_smp);
            end
            default: begin
              tb_errs++;
              $display("unknown trace operation %c", op);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    repeat (6) @(posedge adc_clk); // drain the pipeline
    #1;
    if (chk_pend) begin
      tb_errs++;
      $display("expected values were still waiting at the end of the trace");
    end
    $display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
    if (chk_errs + tb_errs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/afe_checker.sv ====
// response checker for the analog front end core
// compares bus responses at the rising ack, dac words three
// cycles after each sample and ramp steps between dac samples

`timescale 1ns/100ps
`default_nettype none

module afe_checker #(
  parameter int unsigned SAMPLE_W = 14
) (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  input  afe_pkg::bus_rsp_t   bus_rsp_i,
  input  logic [SAMPLE_W-1:0] dac_a_i,
  input  logic [SAMPLE_W-1:0] dac_b_i,
  input  logic                exp_push_i,
  input  logic [1:0]          exp_kind_i,
  input  logic [31:0]         exp_a_i,
  input  logic [31:0]         exp_b_i,
  output int                  err_cnt_o,
  output logic                pend_o
);

  localparam logic [1:0] K_BUS  = 2'd0;
  localparam logic [1:0] K_SMP  = 2'd1;
  localparam logic [1:0] K_RAMP = 2'd2;

  typedef struct packed {
    logic [31:0]         due; // negedge count to compare at
    logic [SAMPLE_W-1:0] a;
    logic [SAMPLE_W-1:0] b;
  } smp_exp_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        chk_rd; // reads only
    logic        err;
  } bus_exp_t;

  smp_exp_t            smp_q[$];
  bus_exp_t            bus_q[$];
  smp_exp_t            se;
  bus_exp_t            be;
  logic [31:0]         ncnt;
  logic                ack_d;
  int                  errs;
  int                  ramp_left;
  logic [SAMPLE_W-1:0] ramp_step;
  logic [SAMPLE_W-1:0] prev_a;
  logic [SAMPLE_W-1:0] prev_b;
  logic [SAMPLE_W-1:0] cur_a;
  logic [SAMPLE_W-1:0] cur_b;

  function automatic logic [SAMPLE_W-1:0] dac_value(input logic [SAMPLE_W-1:0] c);
    return {c[SAMPLE_W-1], ~c[SAMPLE_W-2:0]}; // back to two's complement
  endfunction

  // outputs are stable at the falling edge
  always @(negedge adc_clk) begin
    if (!arst_n_i) begin
      ncnt      = '0;
      ack_d     = 1'b0;
      errs      = 0;
      ramp_left = 0;
    end else begin
      ncnt = ncnt + 1;
      //------------------------------------------------------------------
      // bus response
      if (bus_rsp_i.ack && !ack_d) begin
        if (bus_q.size() == 0) begin
          errs++;
          $display("ack rose with no bus access outstanding");
        end else begin
          be = bus_q.pop_front();
          if (be.chk_rd && bus_rsp_i.rdata !== be.rdata) begin
            errs++;
            $display("Fail bus_rsp_o.rdata: expected %h, got %h", be.rdata, bus_rsp_i.rdata);
          end
          if (bus_rsp_i.err !== be.err) begin
            errs++;
            $display("Fail bus_rsp_o.err: expected %h, got %h", be.err, bus_rsp_i.err);
          end
        end
      end
      ack_d = bus_rsp_i.ack;
      //------------------------------------------------------------------
      // dac samples, three cycles behind the adc
      if (smp_q.size() > 0 && smp_q[0].due == ncnt) begin
        se = smp_q.pop_front();
        if (dac_a_i !== se.a) begin
          errs++;
          $display("Fail dac_dat_a_o: expected %h, got %h", se.a, dac_a_i);
        end
        if (dac_b_i !== se.b) begin
          errs++;
          $display("Fail dac_dat_b_o: expected %h, got %h", se.b, dac_b_i);
        end
      end
      if (ramp_left > 0) begin
        cur_a = dac_value(dac_a_i);
        cur_b = dac_value(dac_b_i);
        if (SAMPLE_W'(cur_a - prev_a) !== ramp_step) begin
          errs++;
          $display("Fail dac_dat_a_o step: expected %h, got %h", ramp_step,
                   SAMPLE_W'(cur_a - prev_a));
        end
        if (SAMPLE_W'(cur_b - prev_b) !== ramp_step) begin
          errs++;
          $display("Fail dac_dat_b_o step: expected %h, got %h", ramp_step,
                   SAMPLE_W'(cur_b - prev_b));
        end
        prev_a    = cur_a;
        prev_b    = cur_b;
        ramp_left = ramp_left - 1;
      end
      //------------------------------------------------------------------
      // new expectations from the driver
      if (exp_push_i) begin
        case (exp_kind_i)
          K_BUS:  bus_q.push_back({exp_a_i, exp_b_i[1], exp_b_i[0]});
          K_SMP:  smp_q.push_back({ncnt + 32'd3, exp_a_i[SAMPLE_W-1:0],
                                   exp_b_i[SAMPLE_W-1:0]});
          K_RAMP: begin
            ramp_step = exp_a_i[SAMPLE_W-1:0];
            ramp_left = int'(exp_b_i);
            prev_a    = dac_value(dac_a_i);
            prev_b    = dac_value(dac_b_i);
          end
          default: begin
            errs++;
            $display("unknown expectation kind from the driver");
          end
        endcase
      end
    end
    err_cnt_o = errs;
    pend_o    = (smp_q.size() != 0) || (bus_q.size() != 0) || (ramp_left != 0);
  end

endmodule

`default_nettype wire

// ==== hdl/afe_top.sv ====
// two channel analog front end core on the adc clock
// adc -> code conversion -> ramp plus feedback mix -> dac,
// three cycles deep; register bank behind the system bus

`timescale 1ns/100ps
`default_nettype none

module afe_top #(
  parameter int unsigned SAMPLE_W = 14
) (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  input  afe_pkg::bus_req_t   bus_req_i,
  output afe_pkg::bus_rsp_t   bus_rsp_o,
  input  logic [SAMPLE_W-1:0] adc_dat_a_i,
  input  logic [SAMPLE_W-1:0] adc_dat_b_i,
  output logic [SAMPLE_W-1:0] dac_dat_a_o,
  output logic [SAMPLE_W-1:0] dac_dat_b_o
);

  afe_pkg::reg_acc_t          reg_acc;   // region 0 strobe
  logic [afe_pkg::BUS_W-1:0]  reg_rdata;
  logic                       reg_err;
  afe_pkg::ctrl_t             ctrl;
  afe_pkg::chan_pair_t        adc_smp;   // converted adc pair
  afe_pkg::chan_pair_t        mix;       // saturated sum
  logic signed [SAMPLE_W-1:0] ramp;

  //----------------------------------------------------------------------
  // system bus and registers
  bus_fsm i_bus (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    .reg_acc_o   (reg_acc),
    .reg_rdata_i (reg_rdata),
    .reg_err_i   (reg_err)
  );

  ctrl_regs i_regs (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .reg_acc_i   (reg_acc),
    .adc_smp_i   (adc_smp),
    .reg_rdata_o (reg_rdata),
    .reg_err_o   (reg_err),
    .ctrl_o      (ctrl)
  );

  //----------------------------------------------------------------------
  // data path
  code_conv #(.SAMPLE_W(SAMPLE_W)) i_conv (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_smp_o   (adc_smp),
    .dac_smp_i   (mix),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  ramp_gen #(.SAMPLE_W(SAMPLE_W)) i_ramp (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .ctrl_i   (ctrl),
    .ramp_o   (ramp)
  );

  mix_sat #(.SAMPLE_W(SAMPLE_W)) i_mix (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .adc_smp_i (adc_smp),
    .ramp_i    (ramp),
    .ctrl_i    (ctrl),
    .mix_o     (mix)
  );

endmodule

`default_nettype wire

// ==== hdl/mix_sat.sv ====
// mixer with saturation, one lane per channel
// adds the ramp to the shifted adc feedback in a one bit
// wider sum and clamps it back to the signed sample range

`timescale 1ns/100ps
`default_nettype none

module mix_sat #(
  parameter int unsigned SAMPLE_W = 14
) (
  input  logic                       adc_clk,
  input  logic                       arst_n_i,
  input  afe_pkg::chan_pair_t        adc_smp_i,
  input  logic signed [SAMPLE_W-1:0] ramp_i,
  input  afe_pkg::ctrl_t             ctrl_i,
  output afe_pkg::chan_pair_t        mix_o
);

  logic signed [SAMPLE_W-1:0] ramp_term; // zero while gen off
  logic signed [SAMPLE_W-1:0] fb_a;
  logic signed [SAMPLE_W-1:0] fb_b;
  logic signed [SAMPLE_W:0]   sum_a;     // one guard bit
  logic signed [SAMPLE_W:0]   sum_b;
  afe_pkg::chan_pair_t        mix_q;

  // clamp when the two top bits differ
  function automatic logic signed [SAMPLE_W-1:0] sat(input logic signed [SAMPLE_W:0] s);
    if (s[SAMPLE_W] != s[SAMPLE_W-1]) begin
      return {s[SAMPLE_W], {(SAMPLE_W-1){~s[SAMPLE_W]}}};
    end
    return s[SAMPLE_W-1:0];
  endfunction

  //----------------------------------------------------------------------
  // feedback and sum
  always_comb begin
    ramp_term = ctrl_i.gen_en ? ramp_i : '0;
    fb_a      = '0;
    fb_b      = '0;
    if (ctrl_i.fb_en) begin
      fb_a = $signed(adc_smp_i.a) >>> ctrl_i.fb_shift; // keeps sign
      fb_b = $signed(adc_smp_i.b) >>> ctrl_i.fb_shift;
    end
    sum_a = ramp_term + fb_a; // sign extended to SAMPLE_W+1
    sum_b = ramp_term + fb_b;
  end

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mix_q <= '0;
    end else begin
      mix_q.a <= sat(sum_a);
      mix_q.b <= sat(sum_b);
    end
  end

  assign mix_o = mix_q;

  // in-range sums pass untouched
  a_pass_a : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    (sum_a[SAMPLE_W] == sum_a[SAMPLE_W-1]) |=> (mix_o.a == $past(sum_a[SAMPLE_W-1:0]))
  ) else $error("channel a altered an in-range sum");

  a_pass_b : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    (sum_b[SAMPLE_W] == sum_b[SAMPLE_W-1]) |=> (mix_o.b == $past(sum_b[SAMPLE_W-1:0]))
  ) else $error("channel b altered an in-range sum");

endmodule

`default_nettype wire

// ==== hdl/code_conv.sv ====
// analog interface code conversion, both directions registered
// adc words come in as unsigned negative slope codes and leave
// as two's complement; dac words go the opposite way
// both use the same rule: keep the msb, invert the rest

`timescale 1ns/100ps
`default_nettype none

module code_conv #(
  parameter int unsigned SAMPLE_W = 14
) (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  input  logic [SAMPLE_W-1:0] adc_dat_a_i,
  input  logic [SAMPLE_W-1:0] adc_dat_b_i,
  output afe_pkg::chan_pair_t adc_smp_o,
  input  afe_pkg::chan_pair_t dac_smp_i,
  output logic [SAMPLE_W-1:0] dac_dat_a_o,
  output logic [SAMPLE_W-1:0] dac_dat_b_o
);

  localparam logic [SAMPLE_W-1:0] DAC_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}}; // 0x1FFF at 14 bits

  afe_pkg::chan_pair_t adc_q;
  logic [SAMPLE_W-1:0] dac_a_q;
  logic [SAMPLE_W-1:0] dac_b_q;

  function automatic logic [SAMPLE_W-1:0] flip_code(input logic [SAMPLE_W-1:0] c);
    return {c[SAMPLE_W-1], ~c[SAMPLE_W-2:0]};
  endfunction

  //----------------------------------------------------------------------
  // adc side, first stage of the data path
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_q <= '0;
    end else begin
      adc_q.a <= flip_code(adc_dat_a_i);
      adc_q.b <= flip_code(adc_dat_b_i);
    end
  end

  //----------------------------------------------------------------------
  // dac side, last stage
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_a_q <= DAC_ZERO; // mid scale out of reset
      dac_b_q <= DAC_ZERO;
    end else begin
      dac_a_q <= flip_code(dac_smp_i.a);
      dac_b_q <= flip_code(dac_smp_i.b);
    end
  end

  assign adc_smp_o   = adc_q;
  assign dac_dat_a_o = dac_a_q;
  assign dac_dat_b_o = dac_b_q;

endmodule

`default_nettype wire

// ==== hdl/ramp_gen.sv ====
// ramp generator, reduced stand-in for the signal generator
// phase accumulator that clears while disabled and wraps
// modulo 2^SAMPLE_W while enabled

`timescale 1ns/100ps
`default_nettype none

module ramp_gen #(
  parameter int unsigned SAMPLE_W = 14
) (
  input  logic                       adc_clk,
  input  logic                       arst_n_i,
  input  afe_pkg::ctrl_t             ctrl_i,
  output logic signed [SAMPLE_W-1:0] ramp_o
);

  logic [SAMPLE_W-1:0] phase_q;
  logic [SAMPLE_W-1:0] step;

  assign step = ctrl_i.step[SAMPLE_W-1:0];

  //----------------------------------------------------------------------
  // phase counter
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= '0;
    end else if (!ctrl_i.gen_en) begin
      phase_q <= '0;            // hold at zero while off
    end else begin
      phase_q <= phase_q + step; // natural wrap
    end
  end

  // phase read as two's complement
  assign ramp_o = $signed(phase_q);

endmodule

`default_nettype wire

// ==== hdl/ctrl_regs.sv ====
// control and status register bank, bus region 0
// holds the enables, feedback shift and ramp step,
// reads back the latest converted adc pair

`timescale 1ns/100ps
`default_nettype none

module ctrl_regs (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  afe_pkg::reg_acc_t         reg_acc_i,
  input  afe_pkg::chan_pair_t       adc_smp_i,
  output logic [afe_pkg::BUS_W-1:0] reg_rdata_o,
  output logic                      reg_err_o,
  output afe_pkg::ctrl_t            ctrl_o
);

  localparam int unsigned HALF_W = afe_pkg::BUS_W / 2; // one adc channel per half

  afe_pkg::ctrl_t      ctrl_q;
  afe_pkg::chan_pair_t adc_q;   // status copy for REG_ADC
  logic                any_stb;

  assign any_stb = reg_acc_i.wr_stb | reg_acc_i.rd_stb;

  //----------------------------------------------------------------------
  // writable registers
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0; // ramp and feedback off
    end else if (reg_acc_i.wr_stb) begin
      case (reg_acc_i.offset)
        afe_pkg::REG_CTRL: begin
          ctrl_q.gen_en   <= reg_acc_i.wdata[0];
          ctrl_q.fb_en    <= reg_acc_i.wdata[1];
          ctrl_q.fb_shift <= reg_acc_i.wdata[4 +: afe_pkg::SHIFT_W];
        end
        afe_pkg::REG_STEP: ctrl_q.step <= reg_acc_i.wdata[afe_pkg::SAMPLE_W-1:0];
        default: ; // read only or unknown
      endcase
    end
  end

  // adc status, refreshed every cycle
  always_ff @(posedge adc_clk) begin
    adc_q <= adc_smp_i;
  end

  //----------------------------------------------------------------------
  // read mux and error flag, same cycle as the strobe
  always_comb begin
    reg_rdata_o = '0;
    reg_err_o   = 1'b0;
    case (reg_acc_i.offset)
      afe_pkg::REG_CTRL: begin
        reg_rdata_o[0]                    = ctrl_q.gen_en;
        reg_rdata_o[1]                    = ctrl_q.fb_en;
        reg_rdata_o[4 +: afe_pkg::SHIFT_W] = ctrl_q.fb_shift;
      end
      afe_pkg::REG_STEP: reg_rdata_o[afe_pkg::SAMPLE_W-1:0] = ctrl_q.step;
      afe_pkg::REG_ADC: begin
        reg_rdata_o[HALF_W-1:0] =
          {{(HALF_W-afe_pkg::SAMPLE_W){adc_q.a[afe_pkg::SAMPLE_W-1]}}, adc_q.a};
        reg_rdata_o[afe_pkg::BUS_W-1:HALF_W] =
          {{(HALF_W-afe_pkg::SAMPLE_W){adc_q.b[afe_pkg::SAMPLE_W-1]}}, adc_q.b};
        reg_err_o = reg_acc_i.wr_stb; // no writes here
      end
      default: reg_err_o = any_stb; // unknown offset
    endcase
  end

  assign ctrl_o = ctrl_q;

  a_one_stb : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    !(reg_acc_i.rd_stb && reg_acc_i.wr_stb)
  ) else $error("read and write strobe together");

endmodule

`default_nettype wire

// ==== hdl/bus_fsm.sv ====
// system bus decoder with a four-phase req/ack handshake
// splits the address into eight regions by the region field,
// strobes the region 0 register bank and answers unmapped
// regions with zero data and no error

`timescale 1ns/100ps
`default_nettype none

module bus_fsm (
  input  logic                          adc_clk,
  input  logic                          arst_n_i,
  input  afe_pkg::bus_req_t             bus_req_i,
  output afe_pkg::bus_rsp_t             bus_rsp_o,
  output afe_pkg::reg_acc_t             reg_acc_o,
  input  logic [afe_pkg::BUS_W-1:0]     reg_rdata_i,
  input  logic                          reg_err_i
);

  afe_pkg::bus_state_e            state_q;
  afe_pkg::bus_state_e            state_d;
  logic [afe_pkg::REGION_W-1:0]   region;   // addr[22:20]
  logic                           cs_ctrl;  // region 0 select
  logic                           in_access;
  logic                           ack_q;
  logic                           err_q;
  logic [afe_pkg::BUS_W-1:0]      rdata_q;

  //----------------------------------------------------------------------
  // region decode, only looked at in ST_ACCESS
  assign region    = bus_req_i.addr[afe_pkg::REGION_LSB +: afe_pkg::REGION_W];
  assign cs_ctrl   = (region == afe_pkg::RGN_CTRL);
  assign in_access = (state_q == afe_pkg::ST_ACCESS);

  // strobe to the register bank
  assign reg_acc_o.wr_stb = in_access & cs_ctrl & bus_req_i.wr;
  assign reg_acc_o.rd_stb = in_access & cs_ctrl & ~bus_req_i.wr;
  assign reg_acc_o.offset = bus_req_i.addr[7:0];
  assign reg_acc_o.wdata  = bus_req_i.wdata;

  //----------------------------------------------------------------------
  // handshake state machine
  always_comb begin
    state_d = state_q;
    case (state_q)
      afe_pkg::ST_IDLE:    if (bus_req_i.req) state_d = afe_pkg::ST_ACCESS;
      afe_pkg::ST_ACCESS:  state_d = afe_pkg::ST_HOLD;     // ack goes up here
      afe_pkg::ST_HOLD:    if (!bus_req_i.req) state_d = afe_pkg::ST_RELEASE;
      afe_pkg::ST_RELEASE: state_d = afe_pkg::ST_IDLE;     // ack drops here
      default:             state_d = afe_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= afe_pkg::ST_IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (in_access) begin
        ack_q <= 1'b1;
        err_q <= cs_ctrl & reg_err_i; // unmapped never errs
      end else if (state_q == afe_pkg::ST_RELEASE) begin
        ack_q <= 1'b0;
        err_q <= 1'b0;
      end
    end
  end

  // read data select, zero for spare regions
  always_ff @(posedge adc_clk) begin
    if (in_access) begin
      rdata_q <= cs_ctrl ? reg_rdata_i : '0;
    end
  end

  assign bus_rsp_o.rdata = rdata_q;
  assign bus_rsp_o.ack   = ack_q;
  assign bus_rsp_o.err   = err_q;

  //----------------------------------------------------------------------
  // protocol checks
  a_ack_needs_req : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    $rose(ack_q) |-> $past(bus_req_i.req)
  ) else $error("ack rose without req");

  // strobe only in the cycle that follows a request seen in ST_IDLE
  a_stb_in_access : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    (reg_acc_o.wr_stb || reg_acc_o.rd_stb) |->
      $past(state_q == afe_pkg::ST_IDLE && bus_req_i.req) ##1
      !(reg_acc_o.wr_stb || reg_acc_o.rd_stb)
  ) else $error("register strobe outside ST_ACCESS");

endmodule

`default_nettype wire

// ==== hdl/afe_pkg.sv ====
// analog front end shared definitions
// sample and bus widths, region map, register offsets,
// bus and register structs, handshake state encoding

`default_nettype none

package afe_pkg;

  //----------------------------------------------------------------------
  // widths
  localparam int unsigned SAMPLE_W   = 14; // adc, dac and data path
  localparam int unsigned BUS_W      = 32; // bus addr and data
  localparam int unsigned REGION_LSB = 20; // region field starts here
  localparam int unsigned REGION_W   = 3;  // eight regions
  localparam int unsigned SHIFT_W    = 3;  // feedback shift field

  //----------------------------------------------------------------------
  // region map and region 0 offsets
  localparam logic [REGION_W-1:0] RGN_CTRL = '0; // control bank
  localparam logic [7:0] REG_CTRL = 8'h00;       // enables and shift
  localparam logic [7:0] REG_STEP = 8'h04;       // ramp step
  localparam logic [7:0] REG_ADC  = 8'h08;       // adc pair, read only

  //----------------------------------------------------------------------
  // bus side
  typedef struct packed {
    logic [BUS_W-1:0] addr;  // byte address
    logic [BUS_W-1:0] wdata; // write data
    logic             wr;    // 1 write, 0 read
    logic             req;   // held until ack seen
  } bus_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata; // valid with ack
    logic             ack;
    logic             err;
  } bus_rsp_t;

  typedef struct packed {
    logic             wr_stb; // one cycle
    logic             rd_stb; // one cycle
    logic [7:0]       offset; // byte offset in region
    logic [BUS_W-1:0] wdata;
  } reg_acc_t;

  //----------------------------------------------------------------------
  // data path
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] a; // channel a
    logic signed [SAMPLE_W-1:0] b; // channel b
  } chan_pair_t;

  typedef struct packed {
    logic                gen_en;   // ramp on
    logic                fb_en;    // feedback on
    logic [SHIFT_W-1:0]  fb_shift; // feedback attenuation
    logic [SAMPLE_W-1:0] step;     // phase increment
  } ctrl_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_HOLD,
    ST_RELEASE
  } bus_state_e;

endpackage

`default_nettype wire
